// ==== Makefile ====
# Verilator flow for the digital clock core

VERILATOR  ?= verilator
FILELIST   ?= sim.f
TOP        ?= tb_digital_clock
RTL_TOP    ?= digital_clock
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing -Wno-fatal
LINT_FLAGS ?= -Wall
SIM_ARGS   ?=

.PHONY: all lint sim clean

all: sim

# lint the RTL on its own, then with the testbench
lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) --top-module $(RTL_TOP) \
		rtl/clock_pkg.sv rtl/bcd_digit_counter.sv rtl/bcd_pair_counter.sv \
		rtl/tick_divider.sv rtl/time_of_day.sv rtl/display_scan.sv rtl/digital_clock.sv
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# a failing run ends in $$fatal, so the exit status carries the result
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== rtl/bcd_digit_counter.sv ====
`timescale 1ns/1ns

module bcd_digit_counter
(
	input  logic                  clk,	// system clock
	input  logic                  reset,	// sync, active high
	input  logic                  increase,	// count enable for this digit
	input  logic                  clear,	// back to zero, beats increase
	input  logic                  load,	// take load_value, beats clear
	input  clock_pkg::bcd_digit_t load_value,	// value for load
	output clock_pkg::bcd_digit_t value,	// current digit
	output logic                  carry	// rolls into next digit
);

	//////////////////////////////////////////////////
	// digit register
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			value <= 4'd0;	// start at zero
		else if (load)
			value <= load_value;	// preset from outside
		else if (clear)
			value <= 4'd0;	// wrap forced by pair limit
		else if (increase)
		begin
			if (value == 4'd9)
				value <= 4'd0;	// 9 -> 0
			else
				value <= value + 4'd1;	// plain step
		end
	end

	//////////////////////////////////////////////////
	// carry out
	//////////////////////////////////////////////////

	// only on the counting step, so one carry per wrap
	always_comb
	begin
		carry = increase && (value == 4'd9);	// next digit steps too
	end

endmodule

// ==== rtl/bcd_pair_counter.sv ====
`timescale 1ns/1ns

module bcd_pair_counter
#(
	parameter clock_pkg::bcd_digit_t UNIT_LIMIT = 4'd9,	// unit digit at wrap
	parameter clock_pkg::bcd_digit_t TENS_LIMIT = 4'd5	// tens digit at wrap
)
(
	input  logic                 clk,	// system clock
	input  logic                 reset,	// sync, active high
	input  logic                 increase,	// step the pair
	input  logic                 set,	// load both digits
	input  clock_pkg::bcd_pair_t set_value,	// preset value
	output clock_pkg::bcd_pair_t value,	// current pair
	output logic                 carry	// wrap to 00, steps the next pair
);

	logic at_limit;	// pair sits on its limit
	logic wrap;	// limit reached and stepping
	logic unit_carry;	// unit 9 -> 0

	//////////////////////////////////////////////////
	// limit detect
	//////////////////////////////////////////////////

	always_comb
	begin
		at_limit = (value.tens == TENS_LIMIT) && (value.unit == UNIT_LIMIT);
		wrap     = increase && at_limit;	// gated, one wrap per step
		carry    = wrap;	// same edge as the clear
	end

	//////////////////////////////////////////////////
	// digits
	//////////////////////////////////////////////////

	bcd_digit_counter unit_part
	(
		.clk        (clk),
		.reset      (reset),
		.increase   (increase),	// every step
		.clear      (wrap),	// back to 0 at limit
		.load       (set),
		.load_value (set_value.unit),
		.value      (value.unit),
		.carry      (unit_carry)
	);

	bcd_digit_counter tens_part
	(
		.clk        (clk),
		.reset      (reset),
		.increase   (unit_carry),	// steps when the unit rolls
		.clear      (wrap),
		.load       (set),
		.load_value (set_value.tens),
		.value      (value.tens),
		.carry      ()	// tens limit always below 9, never used
	);

endmodule

// ==== rtl/clock_pkg.sv ====
package clock_pkg;

	//////////////////////////////////////////////////
	// bcd types
	//////////////////////////////////////////////////

	typedef logic [3:0] bcd_digit_t;	// one bcd digit, 0..9 valid

	typedef struct packed
	{
		bcd_digit_t tens;	// upper digit
		bcd_digit_t unit;	// lower digit
	} bcd_pair_t;	// 8 bits, two digits

	typedef struct packed
	{
		bcd_pair_t hours;	// 00..23
		bcd_pair_t minutes;	// 00..59
		bcd_pair_t seconds;	// 00..59
	} time_bcd_t;	// 24 bits, hh:mm:ss

	//////////////////////////////////////////////////
	// display
	//////////////////////////////////////////////////

	localparam int NUM_DIGITS = 6;	// hh mm ss on the display

	typedef logic [6:0] seg_t;	// g f e d c b a, active high

	// scan order, hours tens first
	typedef enum logic [2:0]
	{
		SCAN_H_TENS,
		SCAN_H_UNIT,
		SCAN_M_TENS,
		SCAN_M_UNIT,
		SCAN_S_TENS,
		SCAN_S_UNIT
	} scan_state_e;

endpackage

// ==== rtl/digital_clock.sv ====
`timescale 1ns/1ns

module digital_clock
#(
	parameter int unsigned TICK_DIVISOR = 50000000,	// clocks per second
	parameter int unsigned SCAN_DIVISOR = 50000	// clocks per shown digit
)
(
	input  logic                             clk,	// system clock
	input  logic                             reset,	// sync, active high
	input  logic                             run,	// level, count while high
	input  logic                             set,	// strobe, load set_time
	input  clock_pkg::time_bcd_t             set_time,	// preset hh:mm:ss
	output clock_pkg::time_bcd_t             time_now,	// current hh:mm:ss
	output clock_pkg::seg_t                  seg,	// segment pattern
	output logic [clock_pkg::NUM_DIGITS-1:0] digit_enable	// one-hot digit select
);

	logic tick;	// one second pulse

	//////////////////////////////////////////////////
	// producer: second tick
	//////////////////////////////////////////////////

	tick_divider
	#(
		.TICK_DIVISOR (TICK_DIVISOR)
	)
	tick_gen
	(
		.clk   (clk),
		.reset (reset),
		.run   (run),
		.set   (set),	// restart the second on a set
		.tick  (tick)
	);

	//////////////////////////////////////////////////
	// buffer: hh:mm:ss registers
	//////////////////////////////////////////////////

	time_of_day time_regs
	(
		.clk      (clk),
		.reset    (reset),
		.tick     (tick),
		.set      (set),	// load beats a tick
		.set_time (set_time),
		.time_now (time_now)
	);

	//////////////////////////////////////////////////
	// consumer: display scan
	//////////////////////////////////////////////////

	display_scan
	#(
		.SCAN_DIVISOR (SCAN_DIVISOR)
	)
	scanner
	(
		.clk          (clk),
		.reset        (reset),
		.time_now     (time_now),
		.seg          (seg),
		.digit_enable (digit_enable)
	);

endmodule

// ==== rtl/display_scan.sv ====
`timescale 1ns/1ns

module display_scan
#(
	parameter int unsigned SCAN_DIVISOR = 50000	// clocks per digit
)
(
	input  logic                                clk,	// system clock
	input  logic                                reset,	// sync, active high
	input  clock_pkg::time_bcd_t                time_now,	// time to show
	output clock_pkg::seg_t                     seg,	// g..a, active high
	output logic [clock_pkg::NUM_DIGITS-1:0]    digit_enable	// one-hot, bit 5 = hours tens
);

	localparam int PRE_W = (SCAN_DIVISOR > 1) ? $clog2(SCAN_DIVISOR) : 1;	// prescaler width
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(SCAN_DIVISOR - 1);	// last count of a step

	logic [PRE_W-1:0]                  prescale;	// clocks in this step
	clock_pkg::scan_state_e            state;	// digit being shown
	clock_pkg::scan_state_e            state_next;
	clock_pkg::bcd_digit_t             digit_sel;	// bcd of the shown digit
	logic [clock_pkg::NUM_DIGITS-1:0]  enable_sel;	// its enable
	clock_pkg::seg_t                   seg_sel;	// decoded pattern

	//////////////////////////////////////////////////
	// prescaler and scan state
	//////////////////////////////////////////////////

	always_comb
	begin
		case (state)
			clock_pkg::SCAN_H_TENS: state_next = clock_pkg::SCAN_H_UNIT;
			clock_pkg::SCAN_H_UNIT: state_next = clock_pkg::SCAN_M_TENS;
			clock_pkg::SCAN_M_TENS: state_next = clock_pkg::SCAN_M_UNIT;
			clock_pkg::SCAN_M_UNIT: state_next = clock_pkg::SCAN_S_TENS;
			clock_pkg::SCAN_S_TENS: state_next = clock_pkg::SCAN_S_UNIT;
			default:                state_next = clock_pkg::SCAN_H_TENS;	// wrap after ss unit
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			prescale <= '0;
			state    <= clock_pkg::SCAN_H_TENS;
		end
		else if (prescale == PRE_LAST)
		begin
			prescale <= '0;
			state    <= state_next;	// next digit
		end
		else
			prescale <= prescale + 1'b1;
	end

	//////////////////////////////////////////////////
	// digit select
	//////////////////////////////////////////////////

	always_comb
	begin
		case (state)
			clock_pkg::SCAN_H_TENS: begin digit_sel = time_now.hours.tens;   enable_sel = 6'b100000; end
			clock_pkg::SCAN_H_UNIT: begin digit_sel = time_now.hours.unit;   enable_sel = 6'b010000; end
			clock_pkg::SCAN_M_TENS: begin digit_sel = time_now.minutes.tens; enable_sel = 6'b001000; end
			clock_pkg::SCAN_M_UNIT: begin digit_sel = time_now.minutes.unit; enable_sel = 6'b000100; end
			clock_pkg::SCAN_S_TENS: begin digit_sel = time_now.seconds.tens; enable_sel = 6'b000010; end
			default:                begin digit_sel = time_now.seconds.unit; enable_sel = 6'b000001; end
		endcase
	end

	// seven segment table, g f e d c b a
	always_comb
	begin
		case (digit_sel)
			4'd0:    seg_sel = 7'b0111111;	// a b c d e f
			4'd1:    seg_sel = 7'b0000110;	// b c
			4'd2:    seg_sel = 7'b1011011;
			4'd3:    seg_sel = 7'b1001111;
			4'd4:    seg_sel = 7'b1100110;
			4'd5:    seg_sel = 7'b1101101;
			4'd6:    seg_sel = 7'b1111101;
			4'd7:    seg_sel = 7'b0000111;
			4'd8:    seg_sel = 7'b1111111;	// all on
			4'd9:    seg_sel = 7'b1101111;
			default: seg_sel = 7'b0000000;	// not bcd, blank
		endcase
	end

	//////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			seg          <= '0;
			digit_enable <= 6'b100000;	// hours tens first
		end
		else
		begin
			seg          <= seg_sel;
			digit_enable <= enable_sel;
		end
	end

endmodule

// ==== rtl/tick_divider.sv ====
`timescale 1ns/1ns

module tick_divider
#(
	parameter int unsigned TICK_DIVISOR = 50000000	// clocks per tick
)
(
	input  logic clk,	// system clock
	input  logic reset,	// sync, active high
	input  logic run,	// count while high
	input  logic set,	// restart the count
	output logic tick	// one clock wide
);

	localparam int CNT_W = (TICK_DIVISOR > 1) ? $clog2(TICK_DIVISOR) : 1;	// counter width
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(TICK_DIVISOR - 1);	// start of a period

	logic [CNT_W-1:0] count;	// clocks left in this period

	//////////////////////////////////////////////////
	// down counter and tick
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset || set)
		begin
			count <= RELOAD;	// fresh period
			tick  <= 1'b0;
		end
		else if (run)
		begin
			if (count == '0)
			begin
				count <= RELOAD;	// period done
				tick  <= 1'b1;	// one pulse
			end
			else
			begin
				count <= count - 1'b1;
				tick  <= 1'b0;
			end
		end
		else
			tick <= 1'b0;	// paused, count holds
	end

endmodule

// ==== rtl/time_of_day.sv ====
`timescale 1ns/1ns

module time_of_day
(
	input  logic                 clk,	// system clock
	input  logic                 reset,	// sync, active high
	input  logic                 tick,	// one second
	input  logic                 set,	// load set_time
	input  clock_pkg::time_bcd_t set_time,	// preset hh:mm:ss
	output clock_pkg::time_bcd_t time_now	// current hh:mm:ss
);

	clock_pkg::bcd_pair_t seconds_value;	// ss
	clock_pkg::bcd_pair_t minutes_value;	// mm
	clock_pkg::bcd_pair_t hours_value;	// hh
	logic                 seconds_carry;	// 59 -> 00
	logic                 minutes_carry;	// 59 -> 00 on a seconds wrap

	//////////////////////////////////////////////////
	// seconds
	//////////////////////////////////////////////////

	bcd_pair_counter
	#(
		.UNIT_LIMIT (4'd9),
		.TENS_LIMIT (4'd5)	// wraps after 59
	)
	seconds_part
	(
		.clk       (clk),
		.reset     (reset),
		.increase  (tick),	// one step per tick
		.set       (set),
		.set_value (set_time.seconds),
		.value     (seconds_value),
		.carry     (seconds_carry)
	);

	//////////////////////////////////////////////////
	// minutes
	//////////////////////////////////////////////////

	bcd_pair_counter
	#(
		.UNIT_LIMIT (4'd9),
		.TENS_LIMIT (4'd5)	// wraps after 59
	)
	minutes_part
	(
		.clk       (clk),
		.reset     (reset),
		.increase  (seconds_carry),	// chained from seconds
		.set       (set),
		.set_value (set_time.minutes),
		.value     (minutes_value),
		.carry     (minutes_carry)
	);

	//////////////////////////////////////////////////
	// hours
	//////////////////////////////////////////////////

	bcd_pair_counter
	#(
		.UNIT_LIMIT (4'd3),
		.TENS_LIMIT (4'd2)	// wraps after 23
	)
	hours_part
	(
		.clk       (clk),
		.reset     (reset),
		.increase  (minutes_carry),	// chained from minutes
		.set       (set),
		.set_value (set_time.hours),
		.value     (hours_value),
		.carry     ()	// day rollover is just the wrap to 00
	);

	// pack back into hh:mm:ss
	assign time_now.hours   = hours_value;
	assign time_now.minutes = minutes_value;
	assign time_now.seconds = seconds_value;

endmodule

// ==== sim.f ====
rtl/clock_pkg.sv
rtl/bcd_digit_counter.sv
rtl/bcd_pair_counter.sv
rtl/tick_divider.sv
rtl/time_of_day.sv
rtl/display_scan.sv
rtl/digital_clock.sv
testbench/tb_digital_clock.sv

// ==== testbench/tb_digital_clock.sv ====
`timescale 1ns/1ns

module tb_digital_clock;

	localparam int unsigned TICK_DIV = 4;	// clocks per second in this run
	localparam int unsigned SCAN_DIV = 3;	// clocks per shown digit
	localparam int ROUNDS = 20;	// random set/run rounds
	localparam int MAX_RANDOM_TICKS = 200;
	localparam int TICKS_BUDGET = 10 + 3 + 5 + ROUNDS * MAX_RANDOM_TICKS;	// all tests
	localparam int WATCHDOG_CYCLES = TICKS_BUDGET * TICK_DIV + 2000;	// margin for overhead

	logic                             clk;
	logic                             reset;
	logic                             run;
	logic                             set;
	clock_pkg::time_bcd_t             set_time;
	clock_pkg::time_bcd_t             time_now;
	clock_pkg::seg_t                  seg;
	logic [clock_pkg::NUM_DIGITS-1:0] digit_enable;

	// compare request from stimulus to the compare process
	logic        cmp_req;
	string       cmp_name;
	logic [31:0] cmp_exp;
	logic [31:0] cmp_act;

	digital_clock
	#(
		.TICK_DIVISOR (TICK_DIV),
		.SCAN_DIVISOR (SCAN_DIV)
	)
	DUT
	(
		.clk          (clk),
		.reset        (reset),
		.run          (run),
		.set          (set),
		.set_time     (set_time),
		.time_now     (time_now),
		.seg          (seg),
		.digit_enable (digit_enable)
	);

	always #20 clk = ~clk;	// 40 ns period

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	function automatic int pair_to_int(clock_pkg::bcd_pair_t p);
		return p.tens * 10 + p.unit;
	endfunction

	function automatic clock_pkg::bcd_pair_t int_to_pair(int v);
		clock_pkg::bcd_pair_t p;
		p.tens = 4'(v / 10);
		p.unit = 4'(v % 10);
		return p;
	endfunction

	// expected time after n seconds via plain seconds of the day
	function automatic clock_pkg::time_bcd_t add_seconds(clock_pkg::time_bcd_t t, int n);
		int total;
		clock_pkg::time_bcd_t r;
		total = pair_to_int(t.hours) * 3600 + pair_to_int(t.minutes) * 60
			+ pair_to_int(t.seconds);
		total = (total + n) % 86400;
		r.hours   = int_to_pair(total / 3600);
		r.minutes = int_to_pair((total / 60) % 60);
		r.seconds = int_to_pair(total % 60);
		return r;
	endfunction

	function automatic clock_pkg::time_bcd_t make_time(int h, int m, int s);
		clock_pkg::time_bcd_t t;
		t.hours   = int_to_pair(h);
		t.minutes = int_to_pair(m);
		t.seconds = int_to_pair(s);
		return t;
	endfunction

	// segment pattern built from the lit segment letters
	function automatic clock_pkg::seg_t seg_of(clock_pkg::bcd_digit_t d);
		string lit;
		byte c;
		clock_pkg::seg_t pattern;
		pattern = '0;
		case (d)
			4'd0:    lit = "abcdef";
			4'd1:    lit = "bc";
			4'd2:    lit = "abdeg";
			4'd3:    lit = "abcdg";
			4'd4:    lit = "bcfg";
			4'd5:    lit = "acdfg";
			4'd6:    lit = "acdefg";
			4'd7:    lit = "abc";
			4'd8:    lit = "abcdefg";
			4'd9:    lit = "abcdfg";
			default: lit = "";	// blank above 9
		endcase
		for (int i = 0; i < lit.len(); i++)
		begin
			c = lit[i];
			pattern[c - "a"] = 1'b1;	// a is bit 0
		end
		return pattern;
	endfunction

	// digit shown under enable bit idx with bit 5 as hours tens
	function automatic clock_pkg::bcd_digit_t digit_at(clock_pkg::time_bcd_t t, int idx);
		case (idx)
			5:       return t.hours.tens;
			4:       return t.hours.unit;
			3:       return t.minutes.tens;
			2:       return t.minutes.unit;
			1:       return t.seconds.tens;
			default: return t.seconds.unit;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// compare
	//////////////////////////////////////////////////

	task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	always
	begin
		wait (cmp_req);
		check(cmp_name, cmp_exp, cmp_act);
		cmp_req = 1'b0;	// hand back to stimulus
	end

	task automatic request_compare(string name, logic [31:0] expected, logic [31:0] actual);
		cmp_name = name;
		cmp_exp  = expected;
		cmp_act  = actual;
		cmp_req  = 1'b1;
		wait (!cmp_req);
	endtask

	//////////////////////////////////////////////////
	// stimulus helpers entered 2 ns after an edge
	//////////////////////////////////////////////////

	task automatic load_time(clock_pkg::time_bcd_t t);
		set      = 1'b1;
		set_time = t;
		run      = 1'b0;
		@(posedge clk);
		#2 set = 1'b0;
		@(posedge clk);
		#2;
	endtask

	// n ticks with run high then pause and settle
	task automatic count_ticks(int n);
		repeat (n * TICK_DIV) @(posedge clk);
		#2 run = 1'b0;
		@(posedge clk);	// last tick lands here
		#2;
	endtask

	task automatic set_and_run(clock_pkg::time_bcd_t t, int n);
		set      = 1'b1;
		set_time = t;
		run      = 1'b1;
		@(posedge clk);	// load edge
		#2 set = 1'b0;
		count_ticks(n);
	endtask

	task automatic resume_ticks(int n);
		run = 1'b1;
		count_ticks(n);
	endtask

	//////////////////////////////////////////////////
	// watchdog
	//////////////////////////////////////////////////

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	initial
	begin
		clock_pkg::time_bcd_t start;
		clock_pkg::time_bcd_t held;
		logic [clock_pkg::NUM_DIGITS-1:0] seen;
		int n;
		int ones;
		int idx;
		clk      = 1'b0;
		reset    = 1'b1;
		run      = 1'b0;
		set      = 1'b0;
		set_time = '0;
		cmp_req  = 1'b0;
		cmp_name = "";
		cmp_exp  = '0;
		cmp_act  = '0;
		void'($urandom(32'hdbaa05ea));	// one seed for the run
		repeat (16) @(posedge clk);
		#2 reset = 1'b0;

		// reset state
		request_compare("reset time", '0, 32'(time_now));
		request_compare("reset enable", 32'h20, 32'(digit_enable));

		// seconds into minutes
		start = make_time(0, 0, 55);
		set_and_run(start, 10);
		request_compare("minute carry", 32'(add_seconds(start, 10)), 32'(time_now));

		// full day wrap through all pairs
		start = make_time(23, 59, 58);
		set_and_run(start, 3);
		request_compare("day wrap", 32'(add_seconds(start, 3)), 32'(time_now));

		// pause holds and resume counts on
		held = add_seconds(start, 3);
		repeat (40) @(posedge clk);
		#2;
		request_compare("pause hold", 32'(held), 32'(time_now));
		resume_ticks(5);
		request_compare("resume", 32'(add_seconds(held, 5)), 32'(time_now));

		// random set values and run lengths
		for (int r = 0; r < ROUNDS; r++)
		begin
			start = make_time($urandom_range(23, 0), $urandom_range(59, 0),
				$urandom_range(59, 0));
			n = $urandom_range(MAX_RANDOM_TICKS, 1);
			set_and_run(start, n);
			request_compare("random round", 32'(add_seconds(start, n)), 32'(time_now));
		end

		////////////////////////////////////////////////// display
		start = make_time(20, 47, 36);
		load_time(start);
		request_compare("display load", 32'(start), 32'(time_now));
		seen = '0;
		repeat (clock_pkg::NUM_DIGITS * SCAN_DIV)
		begin
			@(posedge clk);
			#2;
			ones = $countones(digit_enable);
			request_compare("display one-hot", 1, ones);
			idx = 0;
			for (int b = 0; b < clock_pkg::NUM_DIGITS; b++)
				if (digit_enable[b])
					idx = b;
			seen[idx] = 1'b1;
			request_compare("display seg", 32'(seg_of(digit_at(start, idx))), 32'(seg));
		end
		request_compare("display coverage", 32'h3f, 32'(seen));	// every digit shown

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
